/* common/fePkg.sv */
// Front-end console package: diagnostic function codes, widths, timing counts and FSM states
`default_nettype none

package fePkg;

  ////////////////////////////////////////////////////////////////////////////
  // Diagnostic function codes as decoded by the CLK and CRM boards
  typedef enum logic [6:0] {
    // Clock control
    stopClock            = 7'o000,
    startClock           = 7'o001,
    stepClock            = 7'o002,
    condStep             = 7'o004,
    setReset             = 7'o006,
    clrReset             = 7'o007,
    clrRun               = 7'o010,
    // Clock and burst loads
    burstCtrRh           = 7'o042,
    burstCtrLh           = 7'o043,
    clkSrcRate           = 7'o044,
    setEboxClkDisables   = 7'o045,
    resetParRegs         = 7'o046,
    mboxdisParchkErrstop = 7'o047,
    // Control-RAM writes
    cramWrite1           = 7'o051,
    cramWrite2           = 7'o052,
    cramWrite3           = 7'o053,
    cramWrite4           = 7'o054,
    cramWrite5           = 7'o057,
    // Machine enables
    enableKl             = 7'o067,
    initChannels         = 7'o070,
    writeMbox            = 7'o071,
    ebusLoad             = 7'o076
  } diagFunc;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  localparam int ebusWidth     = 36;
  localparam int cramWidth     = 86;
  localparam int fieldWidth    = 16;
  localparam int charWidth     = 7;
  localparam int charsPerField = 3;
  localparam int fieldsPerWord = 6;

  // Bus cycle timing in clocks
  localparam int strobeCycles = 9;
  localparam int gapCycles    = 4;

  // Master-reset timing
  localparam int crobarCycles       = 100;
  localparam int crobarSettleCycles = 10;
  localparam int syncWaitCycles     = 5;
  localparam int syncMaxSteps       = 5;

  // Data written with the final writeMbox
  localparam logic [ebusWidth-1:0] mboxInitData = 36'o120;

  // Counter widths derived from the counts above
  localparam int busCntWidth   = $clog2(strobeCycles);
  localparam int waitCntWidth  = $clog2(crobarCycles);
  localparam int stepCntWidth  = $clog2(syncMaxSteps + 1);
  localparam int seqIdxWidth   = 5;
  localparam int charCntWidth  = $clog2(charsPerField);
  localparam int fieldCntWidth = $clog2(fieldsPerWord);

  ////////////////////////////////////////////////////////////////////////////
  // FSM states
  typedef enum logic [2:0] {
    crobarHold,
    settle,
    phase1,
    syncWait,
    syncStep,
    phase2,
    done
  } seqState;

  typedef enum logic [1:0] {
    idle,
    strobe,
    gap
  } busState;

endpackage

`default_nettype wire

/* src/diagBusMaster.sv */
// Diagnostic bus master: one strobe cycle at a time, sequencer has priority over the writer
`timescale 1ns/1ps
`default_nettype none

module diagBusMaster (
  input  wire logic                         clk,
  input  wire logic                         rstN,
  input  wire logic                         seqReq,
  input  wire logic                         seqWrite,
  input  wire fePkg::diagFunc               seqFunc,
  input  wire logic [fePkg::ebusWidth-1:0]  seqData,
  input  wire logic                         wrReq,
  input  wire logic                         wrWrite,
  input  wire fePkg::diagFunc               wrFunc,
  input  wire logic [fePkg::ebusWidth-1:0]  wrData,
  output logic                              seqDone,
  output logic                              wrDone,
  output logic                              diagStrobe,
  output logic                              ebusDriving,
  output fePkg::diagFunc                    ds,
  output logic [fePkg::ebusWidth-1:0]       ebusData
);
  import fePkg::*;

  busState                 state;
  logic [busCntWidth-1:0]  cnt;
  // Owner of the cycle in flight, steers Done
  logic                    servingWr;
  // Writer request seen but not yet served
  logic                    wrPend;
  logic                    wrWant;
  logic                    doneNow;
  diagFunc                 selFunc;
  logic                    selWrite;
  logic [ebusWidth-1:0]    selData;

  assign wrWant  = wrReq | wrPend;
  // Last gap cycle
  assign doneNow = (state == gap) && (cnt == busCntWidth'(gapCycles - 1));
  assign seqDone = doneNow & ~servingWr;
  assign wrDone  = doneNow & servingWr;

  // Fixed priority select
  always_comb begin
    selFunc  = seqReq ? seqFunc : wrFunc;
    selWrite = seqReq ? seqWrite : wrWrite;
    selData  = seqReq ? seqData : wrData;
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state       <= idle;
      cnt         <= '0;
      servingWr   <= 1'b0;
      wrPend      <= 1'b0;
      ds          <= stopClock;
      diagStrobe  <= 1'b0;
      ebusDriving <= 1'b0;
      ebusData    <= '0;
    end else begin
      // Keep an unserved writer request until it wins the bus
      if (state == idle && !seqReq && wrWant) begin
        wrPend <= 1'b0;
      end else if (wrReq) begin
        wrPend <= 1'b1;
      end

      unique case (state)
        idle: begin
          if (seqReq || wrWant) begin
            state       <= strobe;
            cnt         <= '0;
            servingWr   <= ~seqReq;
            ds          <= selFunc;
            diagStrobe  <= 1'b1;
            ebusDriving <= selWrite;
            ebusData    <= selWrite ? selData : '0;
          end
        end
        strobe: begin
          if (cnt == busCntWidth'(strobeCycles - 1)) begin
            state       <= gap;
            cnt         <= '0;
            diagStrobe  <= 1'b0;
            ebusDriving <= 1'b0;
            ebusData    <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        gap: begin
          if (doneNow) begin
            state <= idle;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: state <= idle;
      endcase
    end
  end

endmodule

`default_nettype wire

/* masterReset/masterResetSeq.sv */
// Master-reset sequencer: crobar timing, reset step table and MBOX sync loop
`timescale 1ns/1ps
`default_nettype none

module masterResetSeq (
  input  wire logic                         clk,
  input  wire logic                         rstN,
  input  wire logic                         aChangeComingN,
  input  wire logic                         busDone,
  output logic                              crobar,
  output logic                              busReq,
  output logic                              busWrite,
  output logic                              resetDone,
  output logic                              syncError,
  output fePkg::diagFunc                    busFunc,
  output logic [fePkg::ebusWidth-1:0]       busData
);
  import fePkg::*;

  seqState                  state;
  logic [waitCntWidth-1:0]  waitCnt;
  logic [stepCntWidth-1:0]  stepCnt;
  logic [seqIdxWidth-1:0]   stepIdx;
  // A bus cycle is outstanding
  logic                     busy;
  diagFunc                  stepFunc;
  logic                     stepWrite;
  logic [ebusWidth-1:0]     stepData;
  // Entry closes its phase
  logic                     stepLast;

  ////////////////////////////////////////////////////////////////////////////
  // Step table
  always_comb begin
    stepWrite = 1'b0;
    stepData  = '0;
    stepLast  = 1'b0;
    unique case (stepIdx)
      // Clear run, then phase 1
      5'd0:  stepFunc = clrRun;
      5'd1:  begin stepFunc = clkSrcRate;           stepWrite = 1'b1; end
      5'd2:  stepFunc = stopClock;
      5'd3:  stepFunc = setReset;
      5'd4:  begin stepFunc = resetParRegs;         stepWrite = 1'b1; end
      5'd5:  begin stepFunc = mboxdisParchkErrstop; stepWrite = 1'b1; end
      5'd6:  begin stepFunc = burstCtrRh;           stepWrite = 1'b1; end
      5'd7:  begin stepFunc = burstCtrLh;           stepWrite = 1'b1; end
      5'd8:  begin stepFunc = setEboxClkDisables;   stepWrite = 1'b1; end
      5'd9:  stepFunc = startClock;
      5'd10: begin stepFunc = initChannels;         stepWrite = 1'b1; end
      5'd11: begin stepFunc = burstCtrRh; stepWrite = 1'b1; stepLast = 1'b1; end
      // Phase 2
      5'd12: stepFunc = condStep;
      5'd13: stepFunc = clrReset;
      5'd14: begin stepFunc = enableKl;             stepWrite = 1'b1; end
      5'd15: begin stepFunc = ebusLoad;             stepWrite = 1'b1; end
      5'd16: begin
        stepFunc  = writeMbox;
        stepWrite = 1'b1;
        stepData  = mboxInitData;
      end
      // Sentinel clear run
      default: begin
        stepFunc = clrRun;
        stepLast = 1'b1;
      end
    endcase
  end

  // Sync loop issues single steps, otherwise the table drives the bus
  assign busFunc  = (state == syncStep) ? stepClock : stepFunc;
  assign busWrite = (state != syncStep) && stepWrite;
  assign busData  = busWrite ? stepData : '0;

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer FSM
  always_ff @(posedge clk) begin
    if (!rstN) begin
      state     <= crobarHold;
      waitCnt   <= '0;
      stepCnt   <= '0;
      stepIdx   <= '0;
      busy      <= 1'b0;
      busReq    <= 1'b0;
      crobar    <= 1'b1;
      resetDone <= 1'b0;
      syncError <= 1'b0;
    end else begin
      busReq <= 1'b0;
      unique case (state)
        crobarHold: begin
          if (waitCnt == waitCntWidth'(crobarCycles - 1)) begin
            crobar  <= 1'b0;
            waitCnt <= '0;
            state   <= settle;
          end else begin
            waitCnt <= waitCnt + 1'b1;
          end
        end
        settle: begin
          // Clear run goes out directly at the end of the settle time
          if (waitCnt == waitCntWidth'(crobarSettleCycles - 1)) begin
            waitCnt <= '0;
            busReq  <= 1'b1;
            busy    <= 1'b1;
            state   <= phase1;
          end else begin
            waitCnt <= waitCnt + 1'b1;
          end
        end
        phase1, phase2: begin
          if (!busy) begin
            busReq <= 1'b1;
            busy   <= 1'b1;
          end else if (busDone) begin
            busy    <= 1'b0;
            stepIdx <= stepIdx + 1'b1;
            if (stepLast && state == phase1) begin
              state <= syncWait;
            end else if (stepLast) begin
              state     <= done;
              resetDone <= 1'b1;
            end
          end
        end
        syncWait: begin
          if (waitCnt == waitCntWidth'(syncWaitCycles - 1)) begin
            waitCnt <= '0;
            // A change coming already clear
            state   <= aChangeComingN ? phase2 : syncStep;
          end else begin
            waitCnt <= waitCnt + 1'b1;
          end
        end
        syncStep: begin
          if (busy) begin
            if (busDone) begin
              busy    <= 1'b0;
              stepCnt <= stepCnt + 1'b1;
              if (stepCnt == stepCntWidth'(syncMaxSteps - 1)) begin
                // Out of steps, MBOX still not in sync
                syncError <= ~aChangeComingN;
                state     <= phase2;
              end else begin
                state <= syncWait;
              end
            end
          end else if (waitCnt == waitCntWidth'(syncWaitCycles - 1)) begin
            waitCnt <= '0;
            busReq  <= 1'b1;
            busy    <= 1'b1;
          end else begin
            waitCnt <= waitCnt + 1'b1;
          end
        end
        done: resetDone <= 1'b1;
        default: state <= crobarHold;
      endcase
    end
  end

endmodule

`default_nettype wire

/* cramLoader/asciiFieldDecoder.sv */
// ASCIIized character decoder: three characters make one 16-bit field
`timescale 1ns/1ps
`default_nettype none

module asciiFieldDecoder (
  input  wire logic                          clk,
  input  wire logic                          rstN,
  input  wire logic                          charValid,
  input  wire logic [fePkg::charWidth-1:0]   charIn,
  output logic                               fieldValid,
  output logic [fePkg::fieldWidth-1:0]       fieldOut
);
  import fePkg::*;

  logic [charCntWidth-1:0]  charCnt;
  // Six data bits per character
  logic [charWidth-2:0]     sixBits;
  // Low two characters of the field being built
  logic [11:0]              acc;

  // Added 100 only touches the top bit, low six bits are the data for every code
  assign sixBits = charIn[charWidth-2:0];

  // Character count and field strobe
  always_ff @(posedge clk) begin
    if (!rstN) begin
      charCnt    <= '0;
      fieldValid <= 1'b0;
    end else begin
      fieldValid <= 1'b0;
      if (charValid) begin
        if (charCnt == charCntWidth'(charsPerField - 1)) begin
          charCnt    <= '0;
          fieldValid <= 1'b1;
        end else begin
          charCnt <= charCnt + 1'b1;
        end
      end
    end
  end

  // First character lands lowest, each later one six bits up
  always_ff @(posedge clk) begin
    if (charValid) begin
      unique case (charCnt)
        2'd0: acc[5:0] <= sixBits;
        2'd1: acc[11:6] <= sixBits;
        // Third character is cut to the top four bits of the field
        default: fieldOut <= {sixBits[3:0], acc};
      endcase
    end
  end

endmodule

`default_nettype wire

/* cramLoader/cramWordWriter.sv */
// Control-RAM word writer: builds an 86-bit word from six fields and writes it in five cycles
`timescale 1ns/1ps
`default_nettype none

module cramWordWriter (
  input  wire logic                          clk,
  input  wire logic                          rstN,
  input  wire logic                          resetDone,
  input  wire logic                          fieldValid,
  input  wire logic                          busDone,
  input  wire logic [fePkg::fieldWidth-1:0]  fieldIn,
  output logic                               cramReady,
  output logic                               busReq,
  output logic                               busWrite,
  output fePkg::diagFunc                     busFunc,
  output logic [fePkg::ebusWidth-1:0]        busData
);
  import fePkg::*;

  // Bit 0 is the most significant bit of the word
  logic [0:cramWidth-1]      word;
  logic [fieldCntWidth-1:0]  fieldCnt;
  // Write cycles in progress
  logic                      writing;
  logic                      busy;

  assign cramReady = resetDone && !writing;
  assign busWrite  = writing;

  ////////////////////////////////////////////////////////////////////////////
  // Bus placement, slice bit with the lowest number goes highest
  always_comb begin
    unique case (busFunc)
      cramWrite4: busData = {8'b0, word[60:79], 8'b0};
      cramWrite3: busData = {8'b0, word[40:59], 8'b0};
      cramWrite2: busData = {8'b0, word[20:39], 8'b0};
      cramWrite1: busData = {8'b0, word[0:19], 8'b0};
      // Special field on bus bits 35 down to 30
      cramWrite5: busData = {word[80:85], 30'b0};
      default:    busData = '0;
    endcase
  end

  // Load file field order
  always_ff @(posedge clk) begin
    if (cramReady && fieldValid) begin
      unique case (fieldCnt)
        3'd0: word[64:79] <= fieldIn;
        3'd1: word[48:63] <= fieldIn;
        3'd2: word[32:47] <= fieldIn;
        3'd3: word[16:31] <= fieldIn;
        3'd4: word[0:15] <= fieldIn;
        default: word[80:85] <= fieldIn[5:0];
      endcase
    end
  end

  // Collect fields, then walk write 4, 3, 2, 1, 5
  always_ff @(posedge clk) begin
    if (!rstN) begin
      fieldCnt <= '0;
      writing  <= 1'b0;
      busy     <= 1'b0;
      busReq   <= 1'b0;
      busFunc  <= cramWrite4;
    end else begin
      busReq <= 1'b0;
      if (!writing) begin
        if (cramReady && fieldValid) begin
          if (fieldCnt == fieldCntWidth'(fieldsPerWord - 1)) begin
            fieldCnt <= '0;
            writing  <= 1'b1;
          end else begin
            fieldCnt <= fieldCnt + 1'b1;
          end
        end
      end else if (!busy) begin
        busReq <= 1'b1;
        busy   <= 1'b1;
      end else if (busDone) begin
        busy <= 1'b0;
        unique case (busFunc)
          cramWrite4: busFunc <= cramWrite3;
          cramWrite3: busFunc <= cramWrite2;
          cramWrite2: busFunc <= cramWrite1;
          cramWrite1: busFunc <= cramWrite5;
          // Word complete
          default: begin
            busFunc <= cramWrite4;
            writing <= 1'b0;
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* src/feMaster.sv */
// Front-end console master top: reset sequencer, control-RAM loader and diagnostic bus master
`timescale 1ns/1ps
`default_nettype none

module feMaster (
  input  wire logic                          clk,
  input  wire logic                          rstN,
  input  wire logic                          aChangeComingN,
  input  wire logic                          charValid,
  input  wire logic [fePkg::charWidth-1:0]   charIn,
  output logic                               crobar,
  output logic                               diagStrobe,
  output logic                               ebusDriving,
  output logic                               resetDone,
  output logic                               syncError,
  output logic                               cramReady,
  output fePkg::diagFunc                     ds,
  output logic [fePkg::ebusWidth-1:0]        ebusData
);
  import fePkg::*;

  // Sequencer requester
  logic                   seqReq;
  logic                   seqWrite;
  logic                   seqDone;
  diagFunc                seqFunc;
  logic [ebusWidth-1:0]   seqData;

  // Writer requester
  logic                   wrReq;
  logic                   wrWrite;
  logic                   wrDone;
  diagFunc                wrFunc;
  logic [ebusWidth-1:0]   wrData;

  // Decoder to writer
  logic                   fieldValid;
  logic [fieldWidth-1:0]  fieldOut;
  // Characters count only while the loader is ready
  logic                   charTaken;

  assign charTaken = charValid & cramReady;

  masterResetSeq masterResetSeq_i (
    .clk            (clk),
    .rstN           (rstN),
    .aChangeComingN (aChangeComingN),
    .busDone        (seqDone),
    .crobar         (crobar),
    .busReq         (seqReq),
    .busWrite       (seqWrite),
    .resetDone      (resetDone),
    .syncError      (syncError),
    .busFunc        (seqFunc),
    .busData        (seqData)
  );

  asciiFieldDecoder asciiFieldDecoder_i (
    .clk        (clk),
    .rstN       (rstN),
    .charValid  (charTaken),
    .charIn     (charIn),
    .fieldValid (fieldValid),
    .fieldOut   (fieldOut)
  );

  cramWordWriter cramWordWriter_i (
    .clk        (clk),
    .rstN       (rstN),
    .resetDone  (resetDone),
    .fieldValid (fieldValid),
    .busDone    (wrDone),
    .fieldIn    (fieldOut),
    .cramReady  (cramReady),
    .busReq     (wrReq),
    .busWrite   (wrWrite),
    .busFunc    (wrFunc),
    .busData    (wrData)
  );

  diagBusMaster diagBusMaster_i (
    .clk         (clk),
    .rstN        (rstN),
    .seqReq      (seqReq),
    .seqWrite    (seqWrite),
    .seqFunc     (seqFunc),
    .seqData     (seqData),
    .wrReq       (wrReq),
    .wrWrite     (wrWrite),
    .wrFunc      (wrFunc),
    .wrData      (wrData),
    .seqDone     (seqDone),
    .wrDone      (wrDone),
    .diagStrobe  (diagStrobe),
    .ebusDriving (ebusDriving),
    .ds          (ds),
    .ebusData    (ebusData)
  );

endmodule

`default_nettype wire

/* tests/feMasterTb.sv */
// Front-end console master testbench: reset sequence, MBOX sync loop and control-RAM loads
`timescale 1ns/1ps
`default_nettype none

module feMasterTb;
  import fePkg::*;

  localparam int maxRec    = 64;
  localparam int rowCount  = 5;
  localparam int waitLimit = 5000;

  // Stimulus table: MBOX steps until sync, control-RAM words per row
  int stepsTable [rowCount] = '{0, 2, 5, 6, 1};
  int wordsTable [rowCount] = '{1, 1, 1, 1, 1};

  logic                  clk = 1'b0;
  logic                  rstN = 1'b0;
  logic                  aChangeComingN = 1'b0;
  logic                  charValid = 1'b0;
  logic [charWidth-1:0]  charIn = '0;
  logic                  crobar;
  logic                  diagStrobe;
  logic                  ebusDriving;
  logic                  resetDone;
  logic                  syncError;
  logic                  cramReady;
  diagFunc               ds;
  logic [ebusWidth-1:0]  ebusData;

  // Strobes seen by the bus monitor
  int                    nStrobes = 0;
  int                    highLen = 0;
  int                    lowLen = 0;
  int                    stepSeen = 0;
  int                    monErrors = 0;
  logic                  prevStrobe = 1'b0;
  diagFunc               recFunc [maxRec];
  logic [ebusWidth-1:0]  recData [maxRec];
  logic                  recDrv [maxRec];
  logic                  recReady [maxRec];
  logic                  recResetDone [maxRec];
  int                    recLen [maxRec];
  int                    recGap [maxRec];

  // Expected strobe list
  diagFunc               expFunc [maxRec];
  logic                  expWrite [maxRec];
  logic [ebusWidth-1:0]  expData [maxRec];
  int                    nExp = 0;
  int                    nResetList = 0;

  int                    stepsNeeded = 0;
  int                    errCount = 0;
  int                    rowsFailed = 0;
  logic [15:0]           lfsrState = 16'd55;

  always #50 clk = ~clk;

  feMaster feMaster_i (
    .clk            (clk),
    .rstN           (rstN),
    .aChangeComingN (aChangeComingN),
    .charValid      (charValid),
    .charIn         (charIn),
    .crobar         (crobar),
    .diagStrobe     (diagStrobe),
    .ebusDriving    (ebusDriving),
    .resetDone      (resetDone),
    .syncError      (syncError),
    .cramReady      (cramReady),
    .ds             (ds),
    .ebusData       (ebusData)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Bus monitor and MBOX model, sampled on the falling edge
  always @(negedge clk) begin
    if (!rstN) begin
      nStrobes       <= 0;
      highLen        <= 0;
      lowLen         <= 0;
      stepSeen       <= 0;
      prevStrobe     <= 1'b0;
      // A change coming until enough single steps
      aChangeComingN <= (stepsNeeded == 0);
    end else begin
      prevStrobe <= diagStrobe;
      if (diagStrobe && !prevStrobe) begin
        if (nStrobes < maxRec) begin
          recFunc[nStrobes]      <= ds;
          recData[nStrobes]      <= ebusData;
          recDrv[nStrobes]       <= ebusDriving;
          recReady[nStrobes]     <= cramReady;
          recResetDone[nStrobes] <= resetDone;
          recGap[nStrobes]       <= lowLen;
        end
        nStrobes <= nStrobes + 1;
        highLen  <= 1;
        if (ds == stepClock) begin
          stepSeen <= stepSeen + 1;
          if (stepSeen + 1 >= stepsNeeded) begin
            aChangeComingN <= 1'b1;
          end
        end
      end else if (diagStrobe) begin
        highLen <= highLen + 1;
      end
      if (!diagStrobe && prevStrobe) begin
        if (nStrobes > 0 && nStrobes <= maxRec) begin
          recLen[nStrobes - 1] <= highLen;
        end
        lowLen <= 1;
      end else if (!diagStrobe) begin
        lowLen <= lowLen + 1;
      end
      // Bus released between strobes
      if (!diagStrobe && ebusDriving) begin
        $display("ERROR %0t ebusDriving got 1 expected 0", $time);
        monErrors <= monErrors + 1;
      end
      if (!ebusDriving && ebusData != '0) begin
        $display("ERROR %0t ebusData got %0h expected 0", $time, ebusData);
        monErrors <= monErrors + 1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  task automatic reportMismatch(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
    $display("ERROR %0t %s got %0h expected %0h", $time, name, got, exp);
    errCount++;
  endtask

  // Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] nextLfsr(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic randomField(output logic [fieldWidth-1:0] v);
    int k;
    v = '0;
    for (k = 0; k < fieldWidth; k++) begin
      lfsrState = nextLfsr(lfsrState);
      v = {v[fieldWidth-2:0], lfsrState[0]};
    end
  endtask

  // Six bits per character, small values carry an added 100 octal
  function automatic logic [charWidth-1:0] asciiChar(input logic [15:0] v, input int idx);
    logic [5:0] six;
    six = 6'((v >> (6 * idx)) & 16'h3f);
    return (six < 6'o75) ? 7'(six) + 7'o100 : 7'(six);
  endfunction

  // Word bit first goes to bus bit 27, or 35 for the 6-bit slice
  function automatic logic [ebusWidth-1:0] busSlice(input logic [0:cramWidth-1] w,
                                                    input int first, input int len);
    logic [19:0] slice;
    slice = 20'(w >> (cramWidth - first - len));
    if (len == 6) begin
      return 36'(slice[5:0]) << 30;
    end
    return 36'(slice) << 8;
  endfunction

  task automatic addExpected(input diagFunc f, input logic w, input logic [ebusWidth-1:0] d);
    expFunc[nExp]  = f;
    expWrite[nExp] = w;
    expData[nExp]  = d;
    nExp++;
  endtask

  // Clear run, phase 1, single steps, phase 2, sentinel
  task automatic buildResetList(input int steps);
    int k;
    nExp = 0;
    addExpected(clrRun, 1'b0, '0);
    addExpected(clkSrcRate, 1'b1, '0);
    addExpected(stopClock, 1'b0, '0);
    addExpected(setReset, 1'b0, '0);
    addExpected(resetParRegs, 1'b1, '0);
    addExpected(mboxdisParchkErrstop, 1'b1, '0);
    addExpected(burstCtrRh, 1'b1, '0);
    addExpected(burstCtrLh, 1'b1, '0);
    addExpected(setEboxClkDisables, 1'b1, '0);
    addExpected(startClock, 1'b0, '0);
    addExpected(initChannels, 1'b1, '0);
    addExpected(burstCtrRh, 1'b1, '0);
    for (k = 0; k < steps; k++) begin
      addExpected(stepClock, 1'b0, '0);
    end
    addExpected(condStep, 1'b0, '0);
    addExpected(clrReset, 1'b0, '0);
    addExpected(enableKl, 1'b1, '0);
    addExpected(ebusLoad, 1'b1, '0);
    addExpected(writeMbox, 1'b1, mboxInitData);
    addExpected(clrRun, 1'b0, '0);
    nResetList = nExp;
  endtask

  task automatic checkResetValues();
    if (diagStrobe !== 1'b0) reportMismatch("diagStrobe", 64'(diagStrobe), 64'(0));
    if (ebusDriving !== 1'b0) reportMismatch("ebusDriving", 64'(ebusDriving), 64'(0));
    if (resetDone !== 1'b0) reportMismatch("resetDone", 64'(resetDone), 64'(0));
    if (cramReady !== 1'b0) reportMismatch("cramReady", 64'(cramReady), 64'(0));
    if (syncError !== 1'b0) reportMismatch("syncError", 64'(syncError), 64'(0));
    if (crobar !== 1'b1) reportMismatch("crobar", 64'(crobar), 64'(1));
    if (ds !== stopClock) reportMismatch("ds", 64'(ds), 64'(stopClock));
  endtask

  task automatic compareStrobes(input int expSteps);
    int i;
    int last;
    int stepCount;
    stepCount = 0;
    if (nStrobes != nExp) reportMismatch("strobe count", 64'(nStrobes), 64'(nExp));
    last = (nStrobes < nExp) ? nStrobes : nExp;
    for (i = 0; i < last; i++) begin
      if (recFunc[i] != expFunc[i]) begin
        reportMismatch($sformatf("ds[%0d]", i), 64'(recFunc[i]), 64'(expFunc[i]));
      end
      if (recDrv[i] != expWrite[i]) begin
        reportMismatch($sformatf("ebusDriving[%0d]", i), 64'(recDrv[i]), 64'(expWrite[i]));
      end
      if (recData[i] != expData[i]) begin
        reportMismatch($sformatf("ebusData[%0d]", i), 64'(recData[i]), 64'(expData[i]));
      end
      if (recLen[i] != strobeCycles) begin
        reportMismatch($sformatf("strobe length[%0d]", i), 64'(recLen[i]), 64'(strobeCycles));
      end
      // Minimum spacing, shown with the limit as expected value
      if (i > 0 && recGap[i] < gapCycles) begin
        reportMismatch($sformatf("strobe gap[%0d]", i), 64'(recGap[i]), 64'(gapCycles));
      end
      if (recReady[i] != 1'b0) begin
        reportMismatch($sformatf("cramReady[%0d]", i), 64'(recReady[i]), 64'(0));
      end
      if (recResetDone[i] != (i >= nResetList)) begin
        reportMismatch($sformatf("resetDone[%0d]", i), 64'(recResetDone[i]),
                       64'(i >= nResetList));
      end
      if (recFunc[i] == stepClock) stepCount++;
    end
    if (stepCount != expSteps) reportMismatch("stepClock strobes", 64'(stepCount), 64'(expSteps));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // One table row: reset, master-reset sequence, control-RAM words
  task automatic runRow(input int row);
    int n;
    int w;
    int f;
    int c;
    int steps;
    int expSteps;
    logic [fieldWidth-1:0] fld [fieldsPerWord];
    logic [0:cramWidth-1] word;
    steps       = stepsTable[row];
    expSteps    = (steps < syncMaxSteps) ? steps : syncMaxSteps;
    stepsNeeded = steps;
    rstN      <= 1'b0;
    charValid <= 1'b0;
    repeat (16) @(negedge clk);
    checkResetValues();
    rstN <= 1'b1;
    n = 0;
    while (crobar && n < waitLimit) begin
      @(negedge clk);
      n++;
    end
    if (crobar) begin
      $display("row %0d: crobar never dropped after reset", row);
      errCount++;
      return;
    end
    if (n != crobarCycles) reportMismatch("crobar cycles", 64'(n), 64'(crobarCycles));
    n = 0;
    while (!diagStrobe && n < waitLimit) begin
      @(negedge clk);
      n++;
    end
    if (!diagStrobe) begin
      $display("row %0d: no diagnostic strobe after crobar dropped", row);
      errCount++;
      return;
    end
    if (n != crobarSettleCycles + 1) begin
      reportMismatch("first strobe delay", 64'(n), 64'(crobarSettleCycles + 1));
    end
    // Stray character while the loader is not ready
    charValid <= 1'b1;
    charIn    <= 7'o101;
    @(negedge clk);
    charValid <= 1'b0;
    n = 0;
    while (!resetDone && n < waitLimit) begin
      @(negedge clk);
      n++;
    end
    if (!resetDone) begin
      $display("row %0d: master-reset sequence never finished", row);
      errCount++;
      return;
    end
    if (!cramReady) reportMismatch("cramReady", 64'(cramReady), 64'(1));
    if (syncError != (steps > syncMaxSteps)) begin
      reportMismatch("syncError", 64'(syncError), 64'(steps > syncMaxSteps));
    end
    buildResetList(expSteps);
    for (w = 0; w < wordsTable[row]; w++) begin
      for (f = 0; f < fieldsPerWord; f++) begin
        randomField(fld[f]);
      end
      // Load file field order
      word[64:79] = fld[0];
      word[48:63] = fld[1];
      word[32:47] = fld[2];
      word[16:31] = fld[3];
      word[0:15]  = fld[4];
      word[80:85] = fld[5][5:0];
      addExpected(cramWrite4, 1'b1, busSlice(word, 60, 20));
      addExpected(cramWrite3, 1'b1, busSlice(word, 40, 20));
      addExpected(cramWrite2, 1'b1, busSlice(word, 20, 20));
      addExpected(cramWrite1, 1'b1, busSlice(word, 0, 20));
      addExpected(cramWrite5, 1'b1, busSlice(word, 80, 6));
      for (f = 0; f < fieldsPerWord; f++) begin
        for (c = 0; c < charsPerField; c++) begin
          charValid <= 1'b1;
          charIn    <= asciiChar(fld[f], c);
          @(negedge clk);
        end
      end
      charValid <= 1'b0;
      n = 0;
      while (nStrobes < nExp && n < waitLimit) begin
        @(negedge clk);
        n++;
      end
      if (nStrobes < nExp) begin
        $display("row %0d: control-RAM writes did not all appear on the bus", row);
        errCount++;
        return;
      end
      n = 0;
      while (!cramReady && n < waitLimit) begin
        @(negedge clk);
        n++;
      end
      if (!cramReady) begin
        $display("row %0d: cramReady did not return after the writes", row);
        errCount++;
        return;
      end
    end
    compareStrobes(expSteps);
  endtask

  initial begin
    int row;
    int errBefore;
    for (row = 0; row < rowCount; row++) begin
      errBefore = errCount + monErrors;
      runRow(row);
      @(negedge clk);
      if (errCount + monErrors == errBefore) begin
        $display("row %0d stepsNeeded %0d: passed, %0d strobes", row, stepsTable[row], nStrobes);
      end else begin
        rowsFailed++;
        $display("row %0d stepsNeeded %0d: failed", row, stepsTable[row]);
      end
    end
    $display("rows %0d, failed %0d, errors %0d", rowCount, rowsFailed, errCount + monErrors);
    if (errCount + monErrors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
common/fePkg.sv
src/diagBusMaster.sv
masterReset/masterResetSeq.sv
cramLoader/asciiFieldDecoder.sv
cramLoader/cramWordWriter.sv
src/feMaster.sv
tests/feMasterTb.sv

/* run.sh */
#!/bin/sh
# Build and run the feMaster simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module feMasterTb -f sources.f -o feMasterSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/feMasterSim > sim.log 2>&1
runStatus=$?
cat sim.log
if [ $runStatus -ne 0 ]; then
  echo "Simulation exited with status $runStatus"
  exit 1
fi

if grep -q "TB FAILED" sim.log; then
  exit 1
fi

exit 0
